// ==== project.f ====
+incdir+verilog
verilog/tracker_pkg.sv
verilog/column_run_tracker.sv
verilog/column_bin.sv
verilog/centroid_scanner.sv
verilog/seq_divider.sv
verilog/centroid_output.sv
verilog/tracker_top.sv
verif/tb_clock_gen.sv
verif/tracker_checker.sv
verif/tracker_tb.sv

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held over the first 4 rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

// ==== verif/tracker_checker.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module tracker_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  frame_start,
	input logic [`TRK_COL_W-1:0] centroid,
	input logic                  centroid_valid,
	input logic [`TRK_LED_W-1:0] leds
);

	// Scan, divide and output take about 120 cycles at worst
	localparam int RESULT_WAIT = 135;

	int exp_q [$];
	int error_count = 0;
	int check_count = 0;
	// Expected contents of the DUT centroid register
	int held_cent = 0;
	bit leds_live = 1'b0;
	bit pending = 1'b0;
	int wait_cycles = 0;
	int exp_cent;
	logic [`TRK_LED_W-1:0] exp_leds;

	// One LED per band of ten columns, band 0 on the MSB
	function automatic logic [`TRK_LED_W-1:0] led_pattern(input int cent);
		int band;
		band = cent / `TRK_LED_BAND;
		if (band > `TRK_LED_W - 1) begin
			band = `TRK_LED_W - 1;
		end
		return {1'b1, {(`TRK_LED_W - 1){1'b0}}} >> band;
	endfunction

	task automatic add_expected(input int value);
		exp_q.push_back(value);
	endtask

	task automatic finish_checks();
		if (pending) begin
			error_count++;
			$display("Missing centroid_valid after the last frame_start");
		end else if (exp_q.size() != 0) begin
			error_count++;
			$display("%0d expected centroids were never produced", exp_q.size());
		end
	endtask

	////////////////////////////////////////
	// Sampled on the falling edge
	////////////////////////////////////////

	always @(negedge clk) begin
		if (rst) begin
			// Skip the power-up edge at time zero
			if ($time > 0) begin
				check_count++;
				if (leds !== '0) begin
					error_count++;
					$display("ERR %0t: leds = %b, expected %b", $time, leds,
						{`TRK_LED_W{1'b0}});
				end
				if (centroid_valid !== 1'b0) begin
					error_count++;
					$display("centroid_valid is set during reset");
				end
			end
			held_cent = 0;
			leds_live = 1'b0;
			pending = 1'b0;
		end else begin
			// leds lags the centroid register by one cycle
			if (leds_live) begin
				exp_leds = led_pattern(held_cent);
				check_count++;
				if (leds !== exp_leds) begin
					error_count++;
					$display("ERR %0t: leds = %b, expected %b", $time, leds, exp_leds);
				end
			end
			leds_live = 1'b1;

			if (frame_start) begin
				pending = 1'b1;
				wait_cycles = 0;
			end else if (pending && !centroid_valid) begin
				wait_cycles++;
				if (wait_cycles > RESULT_WAIT) begin
					error_count++;
					$display("No centroid_valid within %0d cycles of frame_start", RESULT_WAIT);
					pending = 1'b0;
					if (exp_q.size() != 0) begin
						exp_cent = exp_q.pop_front();
					end
				end
			end

			if (centroid_valid) begin
				if (!pending) begin
					error_count++;
					$display("Unexpected centroid_valid at %0t with no frame waiting", $time);
				end else if (exp_q.size() == 0) begin
					error_count++;
					$display("centroid_valid arrived but no expected centroid is queued");
					pending = 1'b0;
				end else begin
					exp_cent = exp_q.pop_front();
					pending = 1'b0;
					check_count++;
					if (centroid !== exp_cent) begin
						error_count++;
						$display("ERR %0t: centroid = %0d, expected %0d", $time, centroid, exp_cent);
					end
					held_cent = exp_cent;
				end
			end
		end
	end

endmodule

// ==== verif/tracker_tb.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module tracker_tb;

	localparam int ROWS       = 8;
	localparam int FULL_ROWS  = 66;
	localparam int NUM_FRAMES = 14;
	localparam int GAP_CYCLES = 150;
	localparam int RUN_MAX    = (1 << `TRK_RUN_W) - 1;
	// At most two cycles per pixel, plus the gap after each frame
	localparam int TIMEOUT_CYCLES = (NUM_FRAMES - 1) * (ROWS * `TRK_COLS * 2 + 200)
		+ (FULL_ROWS * `TRK_COLS * 2 + 200);

	localparam int KIND_RANDOM = 0;
	localparam int KIND_EMPTY  = 1;
	localparam int KIND_FULL   = 2;
	localparam int KIND_SINGLE = 3;

	logic                  clk;
	logic                  rst;
	tracker_pkg::pixel_t   pixel;
	logic                  frame_start;
	logic [`TRK_COL_W-1:0] centroid;
	logic                  centroid_valid;
	logic [`TRK_LED_W-1:0] leds;

	integer seed;
	int cycle_count = 0;
	int frame_count;
	// Reference model of runs and column maxima
	int model_run [`TRK_COLS];
	int model_max [`TRK_COLS];

	tb_clock_gen u_clock (
		.clk (clk),
		.rst (rst)
	);

	tracker_top UUT (
		.clk            (clk),
		.rst            (rst),
		.pixel          (pixel),
		.frame_start    (frame_start),
		.centroid       (centroid),
		.centroid_valid (centroid_valid),
		.leds           (leds)
	);

	tracker_checker u_checker (
		.clk            (clk),
		.rst            (rst),
		.frame_start    (frame_start),
		.centroid       (centroid),
		.centroid_valid (centroid_valid),
		.leds           (leds)
	);

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send_pixel(input int col, input bit hit);
		// Occasional idle strobe with junk on the other fields
		if (($random(seed) & 3) == 0) begin
			pixel.valid = 1'b0;
			pixel.col = `TRK_COL_W'($unsigned($random(seed)) % `TRK_COLS);
			pixel.hit = (($random(seed) & 1) == 1);
			next_cycle();
		end
		pixel.valid = 1'b1;
		pixel.col = col[`TRK_COL_W-1:0];
		pixel.hit = hit;
		next_cycle();
		if (!hit) begin
			model_run[col] = 0;
		end else if (model_run[col] < RUN_MAX) begin
			model_run[col]++;
		end
		if (model_run[col] > model_max[col]) begin
			model_max[col] = model_run[col];
		end
	endtask

	task automatic end_frame();
		int area;
		int moment;
		int expected;
		pixel.valid = 1'b0;
		// Let the last sample reach its bin
		repeat (2) next_cycle();
		area = 0;
		moment = 0;
		for (int c = 0; c < `TRK_COLS; c++) begin
			area += model_max[c];
			moment += model_max[c] * c;
		end
		expected = (area == 0) ? 0 : moment / area;
		u_checker.add_expected(expected);
		$display("Frame %0d: area %0d, moment %0d, centroid %0d",
			frame_count, area, moment, expected);
		frame_start = 1'b1;
		next_cycle();
		frame_start = 1'b0;
		for (int c = 0; c < `TRK_COLS; c++) begin
			model_run[c] = 0;
			model_max[c] = 0;
		end
		repeat (GAP_CYCLES) next_cycle();
		frame_count++;
	endtask

	task automatic run_frame(input int kind, input int lit_col);
		int rows;
		int density;
		bit hit;
		rows = (kind == KIND_FULL) ? FULL_ROWS : ROWS;
		// Hit chance in eighths, per frame
		density = $unsigned($random(seed)) % 9;
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < `TRK_COLS; c++) begin
				case (kind)
					KIND_EMPTY:  hit = 1'b0;
					KIND_FULL:   hit = 1'b1;
					KIND_SINGLE: hit = (c == lit_col);
					default:     hit = (($random(seed) & 7) < density);
				endcase
				send_pixel(c, hit);
			end
		end
		end_frame();
	endtask

	////////////////////////////////////////
	// Timeout
	////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'hfa2f_df84;
		pixel = '0;
		frame_start = 1'b0;
		frame_count = 0;
		for (int c = 0; c < `TRK_COLS; c++) begin
			model_run[c] = 0;
			model_max[c] = 0;
		end
		wait (rst == 1'b0);
		next_cycle();

		run_frame(KIND_RANDOM, 0);
		run_frame(KIND_EMPTY, 0);
		run_frame(KIND_RANDOM, 0);
		run_frame(KIND_FULL, 0);
		run_frame(KIND_RANDOM, 0);
		run_frame(KIND_SINGLE, 0);
		run_frame(KIND_RANDOM, 0);
		run_frame(KIND_SINGLE, 45);
		run_frame(KIND_RANDOM, 0);
		run_frame(KIND_SINGLE, 79);
		repeat (4) run_frame(KIND_RANDOM, 0);

		// Last result may still be in flight
		while (u_checker.pending) begin
			next_cycle();
		end
		u_checker.finish_checks();
		$display("Frames: %0d  checks: %0d  errors: %0d",
			frame_count, u_checker.check_count, u_checker.error_count);
		if (u_checker.error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/centroid_output.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module centroid_output (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`TRK_MOMENT_W-1:0] quotient,
	input  logic                     div_done,
	output logic [`TRK_COL_W-1:0]    centroid,
	output logic                     centroid_valid,
	output logic [`TRK_LED_W-1:0]    leds
);

	logic [`TRK_COL_W-1:0] band;
	logic [`TRK_LED_W-1:0] leds_next;

	// Band 0 on the MSB, right-hand columns collapse onto the LSB
	always_comb begin
		band = centroid / `TRK_COL_W'(`TRK_LED_BAND);
		if (band > `TRK_COL_W'(`TRK_LED_W - 1)) begin
			band = `TRK_COL_W'(`TRK_LED_W - 1);
		end
		for (int i = 0; i < `TRK_LED_W; i++) begin
			leds_next[i] = (band == `TRK_COL_W'(`TRK_LED_W - 1 - i));
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			centroid       <= '0;
			centroid_valid <= 1'b0;
			leds           <= '0;
		end else begin
			centroid_valid <= div_done;
			if (div_done) begin
				centroid <= quotient[`TRK_COL_W-1:0];
			end
			leds <= leds_next;
		end
	end

endmodule

// ==== verilog/centroid_scanner.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module centroid_scanner (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  frame_start,
	input  logic [`TRK_COLS-1:0][`TRK_RUN_W-1:0]  heights,
	output tracker_pkg::sums_t                    sums,
	output logic                                  sums_done
);

	logic                    active;
	logic [`TRK_COL_W-1:0]   col;
	logic                    last_col;

	// Height of the current column and its weighted value
	logic [`TRK_RUN_W-1:0]    cur_height;
	logic [`TRK_AREA_W-1:0]   area_term;
	logic [`TRK_MOMENT_W-1:0] moment_term;

	assign cur_height  = heights[col];
	assign last_col    = (col == `TRK_COL_W'(`TRK_COLS - 1));
	assign area_term   = `TRK_AREA_W'(cur_height);
	assign moment_term = `TRK_MOMENT_W'(cur_height) * `TRK_MOMENT_W'(col);

	////////////////////////////////////////
	// Scan control
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active    <= 1'b0;
			col       <= '0;
			sums_done <= 1'b0;
		end else if (frame_start) begin
			// Restart even if a scan is still running
			active    <= 1'b1;
			col       <= '0;
			sums_done <= 1'b0;
		end else if (active) begin
			if (last_col) begin
				active    <= 1'b0;
				col       <= '0;
				sums_done <= 1'b1;
			end else begin
				col       <= col + 1'b1;
				sums_done <= 1'b0;
			end
		end else begin
			sums_done <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Accumulators
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sums <= '0;
		end else if (frame_start) begin
			sums <= '0;
		end else if (active) begin
			sums.area   <= sums.area + area_term;
			sums.moment <= sums.moment + moment_term;
		end
	end

	// Column counter stays inside the snapshot array
	a_scan_col_range: assert property (
		@(posedge clk) disable iff (rst)
		col <= `TRK_COL_W'(`TRK_COLS - 1)
	) else $error("scan column %0d past end", col);

endmodule

// ==== verilog/column_bin.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module column_bin #(
	parameter int COL_IDX = 0
) (
	input  logic                     clk,
	input  logic                     rst,
	input  tracker_pkg::col_sample_t sample,
	input  logic                     frame_start,
	output logic [`TRK_RUN_W-1:0]    height
);

	// Tallest run of this column in the current frame
	logic [`TRK_RUN_W-1:0] max_run;
	logic                  mine;

	assign mine = sample.valid && (sample.col == `TRK_COL_W'(COL_IDX));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			max_run <= '0;
			height  <= '0;
		end else if (frame_start) begin
			// Snapshot for the scanner, then start over
			height  <= max_run;
			max_run <= '0;
		end else if (mine && (sample.run > max_run)) begin
			max_run <= sample.run;
		end
	end

endmodule

// ==== verilog/column_run_tracker.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module column_run_tracker (
	input  logic                     clk,
	input  logic                     rst,
	input  tracker_pkg::pixel_t      pixel,
	input  logic                     frame_start,
	output tracker_pkg::col_sample_t sample
);

	// One run counter per column
	logic [`TRK_RUN_W-1:0] runs [`TRK_COLS];
	logic [`TRK_RUN_W-1:0] cur_run;
	logic [`TRK_RUN_W-1:0] next_run;

	assign cur_run = runs[pixel.col];

	// Hit extends the run, miss breaks it
	always_comb begin
		if (!pixel.hit) begin
			next_run = '0;
		end else if (&cur_run) begin
			// Saturated
			next_run = cur_run;
		end else begin
			next_run = cur_run + 1'b1;
		end
	end

	////////////////////////////////////////
	// Counter array
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `TRK_COLS; i++) begin
				runs[i] <= '0;
			end
		end else if (frame_start) begin
			// New frame starts all columns from zero
			for (int i = 0; i < `TRK_COLS; i++) begin
				runs[i] <= '0;
			end
		end else if (pixel.valid) begin
			runs[pixel.col] <= next_run;
		end
	end

	////////////////////////////////////////
	// Sample register
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sample <= '0;
		end else begin
			// Pixel coinciding with frame_start is dropped
			sample.valid <= pixel.valid && !frame_start;
			sample.col   <= pixel.col;
			sample.run   <= next_run;
		end
	end

	// Upstream must keep column addresses inside the frame
	a_pixel_col_range: assert property (
		@(posedge clk) disable iff (rst)
		pixel.valid |-> (pixel.col < `TRK_COLS)
	) else $error("pixel column %0d out of range", pixel.col);

endmodule

// ==== verilog/seq_divider.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module seq_divider #(
	parameter int DIV_W = `TRK_MOMENT_W
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic [DIV_W-1:0] dividend,
	input  logic [DIV_W-1:0] divisor,
	output logic [DIV_W-1:0] quotient,
	output logic             done
);

	localparam int SHIFT_W = $clog2(DIV_W);

	typedef enum logic [1:0] {
		st_idle,
		st_norm,
		st_sub
	} state_t;

	state_t             state;
	// Partial remainder and aligned divisor
	logic [DIV_W-1:0]   rem;
	logic [DIV_W-1:0]   dsor;
	// Current quotient bit position
	logic [SHIFT_W-1:0] shift;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= st_idle;
			rem      <= '0;
			dsor     <= '0;
			shift    <= '0;
			quotient <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					// Requests while busy are never seen here
					if (start) begin
						quotient <= '0;
						if ((dividend == '0) || (divisor == '0)) begin
							done <= 1'b1;
						end else begin
							rem   <= dividend;
							dsor  <= divisor;
							shift <= '0;
							state <= st_norm;
						end
					end
				end

				////////////////////////////////////////
				// Align divisor under the dividend
				////////////////////////////////////////
				st_norm: begin
					if ((dsor < rem) && !dsor[DIV_W-1]) begin
						dsor  <= dsor << 1;
						shift <= shift + 1'b1;
					end else begin
						state <= st_sub;
					end
				end

				////////////////////////////////////////
				// Restoring subtraction, one bit per cycle
				////////////////////////////////////////
				st_sub: begin
					if (rem >= dsor) begin
						rem             <= rem - dsor;
						quotient[shift] <= 1'b1;
					end
					if (shift == '0) begin
						state <= st_idle;
						done  <= 1'b1;
					end else begin
						dsor  <= dsor >> 1;
						shift <= shift - 1'b1;
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Completion is a single-cycle pulse
	a_done_pulse: assert property (
		@(posedge clk) disable iff (rst)
		done |=> !done
	) else $error("done held for more than one cycle");

endmodule

// ==== verilog/tracker_params.svh ====
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// Frame geometry
`define TRK_COLS 80
`define TRK_COL_W 7

// Run heights saturate at 63
`define TRK_RUN_W 6

// Accumulator widths, sized for 80 columns at height 63
`define TRK_AREA_W 13
`define TRK_MOMENT_W 18

// LED display
`define TRK_LED_W 8
`define TRK_LED_BAND 10

`endif

// ==== verilog/tracker_pkg.sv ====
`include "tracker_params.svh"

package tracker_pkg;

	////////////////////////////////////////
	// Stream types
	////////////////////////////////////////

	// Thresholded input pixel
	typedef struct packed {
		logic                  valid;
		logic [`TRK_COL_W-1:0] col;
		logic                  hit;
	} pixel_t;

	// Run height of one column after a pixel
	typedef struct packed {
		logic                  valid;
		logic [`TRK_COL_W-1:0] col;
		logic [`TRK_RUN_W-1:0] run;
	} col_sample_t;

	////////////////////////////////////////
	// Frame results
	////////////////////////////////////////

	typedef struct packed {
		logic [`TRK_AREA_W-1:0]   area;
		logic [`TRK_MOMENT_W-1:0] moment;
	} sums_t;

endpackage

// ==== verilog/tracker_top.sv ====
`timescale 1ns/1ps
`include "tracker_params.svh"

module tracker_top (
	input  logic                  clk,
	input  logic                  rst,
	input  tracker_pkg::pixel_t   pixel,
	input  logic                  frame_start,
	output logic [`TRK_COL_W-1:0] centroid,
	output logic                  centroid_valid,
	output logic [`TRK_LED_W-1:0] leds
);

	tracker_pkg::col_sample_t                sample;
	logic [`TRK_COLS-1:0][`TRK_RUN_W-1:0]    heights;
	tracker_pkg::sums_t                      sums;
	logic                                    sums_done;
	logic [`TRK_MOMENT_W-1:0]                quotient;
	logic                                    div_done;

	column_run_tracker u_tracker (
		.clk         (clk),
		.rst         (rst),
		.pixel       (pixel),
		.frame_start (frame_start),
		.sample      (sample)
	);

	////////////////////////////////////////
	// One max-hold bin per column
	////////////////////////////////////////

	for (genvar i = 0; i < `TRK_COLS; i++) begin : g_bin
		column_bin #(
			.COL_IDX (i)
		) u_bin (
			.clk         (clk),
			.rst         (rst),
			.sample      (sample),
			.frame_start (frame_start),
			.height      (heights[i])
		);
	end

	centroid_scanner u_scanner (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.heights     (heights),
		.sums        (sums),
		.sums_done   (sums_done)
	);

	// Area is zero-extended to the moment width
	seq_divider #(
		.DIV_W (`TRK_MOMENT_W)
	) u_divider (
		.clk      (clk),
		.rst      (rst),
		.start    (sums_done),
		.dividend (sums.moment),
		.divisor  ({{(`TRK_MOMENT_W - `TRK_AREA_W){1'b0}}, sums.area}),
		.quotient (quotient),
		.done     (div_done)
	);

	centroid_output u_output (
		.clk            (clk),
		.rst            (rst),
		.quotient       (quotient),
		.div_done       (div_done),
		.centroid       (centroid),
		.centroid_valid (centroid_valid),
		.leds           (leds)
	);

endmodule
